// File: rtl/tetris_pkg.sv
package tetris_pkg;

    // playfield geometry, row 0 at the top
    localparam int PLAYFIELD_ROWS = 20;
    localparam int PLAYFIELD_COLS = 10;

    // cell contents, blank must stay at zero
    typedef enum logic [3:0] {
        BLANK   = 4'd0,
        I       = 4'd1,
        O       = 4'd2,
        T       = 4'd3,
        S       = 4'd4,
        Z       = 4'd5,
        J       = 4'd6,
        L       = 4'd7,
        GARBAGE = 4'd8
    } tile_t;

    typedef logic [4:0] row_idx_t;
    typedef logic [3:0] col_idx_t;

    // one full row of tiles, column 0 in the low nibble
    typedef tile_t [PLAYFIELD_COLS-1:0] board_row_t;

    typedef logic [9:0] lines_t;

    // sprint timer fields
    typedef logic [3:0] digit_t;
    typedef logic [5:0] sixty_t;

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        IN_GAME    = 2'd1,
        TOPPED_OUT = 2'd2
    } status_t;

endpackage

// File: rtl/playfield_store.sv
`timescale 1ns/100ps

module playfield_store (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  game_start,
    input  logic                  accept,
    input  logic                  lock,
    input  logic                  load_garbage,
    input  tetris_pkg::tile_t     lock_type,
    input  tetris_pkg::row_idx_t  lock_rows [4],
    input  tetris_pkg::col_idx_t  lock_cols [4],
    input  tetris_pkg::col_idx_t  hole_col,
    input  logic [tetris_pkg::PLAYFIELD_ROWS-1:0] row_full,
    input  logic [tetris_pkg::PLAYFIELD_ROWS-1:0] row_empty,
    output tetris_pkg::board_row_t board [tetris_pkg::PLAYFIELD_ROWS]
);
    import tetris_pkg::*;

    localparam board_row_t BLANK_ROW = '{default: BLANK};

    board_row_t cleaned    [PLAYFIELD_ROWS];
    board_row_t board_next [PLAYFIELD_ROWS];
    board_row_t garbage_row;

    // incoming garbage line with its single hole
    always_comb begin
        for (int c = 0; c < PLAYFIELD_COLS; c++) begin
            garbage_row[c] = (c == hole_col) ? BLANK : GARBAGE;
        end
    end

    always_comb begin
        // full rows vanish this cycle
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            cleaned[r]    = row_full[r] ? BLANK_ROW : board[r];
            board_next[r] = cleaned[r];
        end

        // a row above an empty row drops into it and leaves a blank behind;
        // the move pass runs second so a chain of drops still lands
        for (int r = 1; r < PLAYFIELD_ROWS; r++) begin
            if (row_empty[r]) begin
                board_next[r-1] = BLANK_ROW;
            end
        end
        for (int r = 1; r < PLAYFIELD_ROWS; r++) begin
            if (row_empty[r]) begin
                board_next[r] = cleaned[r-1];
            end
        end

        if (game_start) begin
            for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
                board_next[r] = BLANK_ROW;
            end
        end else if (accept && lock) begin
            // only seen on a settled board, so the collapse above is a no-op
            for (int k = 0; k < 4; k++) begin
                if (lock_rows[k] < PLAYFIELD_ROWS && lock_cols[k] < PLAYFIELD_COLS) begin
                    board_next[lock_rows[k]][lock_cols[k]] = lock_type;
                end
            end
        end else if (accept && load_garbage) begin
            // whole stack pushed up, top row falls off
            for (int r = 0; r < PLAYFIELD_ROWS - 1; r++) begin
                board_next[r] = board[r+1];
            end
            board_next[PLAYFIELD_ROWS-1] = garbage_row;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
                board[r] <= BLANK_ROW;
            end
        end else begin
            for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
                board[r] <= board_next[r];
            end
        end
    end

endmodule

// File: rtl/line_tracker.sv
`timescale 1ns/100ps

module line_tracker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   game_start,
    input  tetris_pkg::board_row_t board [tetris_pkg::PLAYFIELD_ROWS],
    output logic [tetris_pkg::PLAYFIELD_ROWS-1:0] row_full,
    output logic [tetris_pkg::PLAYFIELD_ROWS-1:0] row_empty,
    output logic                   busy,
    output tetris_pkg::lines_t     lines_cleared
);
    import tetris_pkg::*;

    logic   hole_below;
    logic   seen_tiles;
    lines_t full_count;

    // per-row occupancy
    always_comb begin
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            row_full[r]  = 1'b1;
            row_empty[r] = 1'b1;
            for (int c = 0; c < PLAYFIELD_COLS; c++) begin
                if (board[r][c] == BLANK) begin
                    row_full[r] = 1'b0;
                end else begin
                    row_empty[r] = 1'b0;
                end
            end
        end
    end

    // scan downward looking for an empty row under occupied ones
    always_comb begin
        hole_below = 1'b0;
        seen_tiles = 1'b0;
        full_count = '0;
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            if (row_empty[r] && seen_tiles) begin
                hole_below = 1'b1;
            end
            if (!row_empty[r]) begin
                seen_tiles = 1'b1;
            end
            full_count = full_count + lines_t'(row_full[r]);
        end
    end

    assign busy = (|row_full) || hole_below;

    // full rows are blanked on the same edge, so each is counted once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lines_cleared <= '0;
        end else if (game_start) begin
            lines_cleared <= '0;
        end else begin
            lines_cleared <= lines_cleared + full_count;
        end
    end

endmodule

// File: rtl/sprint_timer.sv
`timescale 1ns/100ps

module sprint_timer #(
    parameter int TICKS_PER_MS = 50000
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                game_start,
    input  logic                run,
    output tetris_pkg::digit_t  time_ms,
    output tetris_pkg::digit_t  time_cs,
    output tetris_pkg::digit_t  time_ds,
    output tetris_pkg::sixty_t  time_sec,
    output tetris_pkg::sixty_t  time_min
);
    import tetris_pkg::*;

    localparam int PRESC_W = (TICKS_PER_MS > 1) ? $clog2(TICKS_PER_MS) : 1;
    localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(TICKS_PER_MS - 1);

    logic [PRESC_W-1:0] presc;
    logic               ms_step;
    logic               ms_wrap;
    logic               cs_wrap;
    logic               ds_wrap;
    logic               sec_wrap;
    logic               min_wrap;

    // one step per millisecond of play
    assign ms_step = run && (presc == PRESC_LAST);

    // carry chain
    assign ms_wrap  = ms_step  && (time_ms  == digit_t'(9));
    assign cs_wrap  = ms_wrap  && (time_cs  == digit_t'(9));
    assign ds_wrap  = cs_wrap  && (time_ds  == digit_t'(9));
    assign sec_wrap = ds_wrap  && (time_sec == sixty_t'(59));
    assign min_wrap = sec_wrap && (time_min == sixty_t'(59));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc <= '0;
        end else if (game_start || ms_step) begin
            presc <= '0;
        end else if (run) begin
            presc <= presc + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            time_ms  <= '0;
            time_cs  <= '0;
            time_ds  <= '0;
            time_sec <= '0;
            time_min <= '0;
        end else if (game_start) begin
            time_ms  <= '0;
            time_cs  <= '0;
            time_ds  <= '0;
            time_sec <= '0;
            time_min <= '0;
        end else begin
            if (ms_step) begin
                time_ms <= ms_wrap ? '0 : time_ms + 1'b1;
            end
            if (ms_wrap) begin
                time_cs <= cs_wrap ? '0 : time_cs + 1'b1;
            end
            if (cs_wrap) begin
                time_ds <= ds_wrap ? '0 : time_ds + 1'b1;
            end
            if (ds_wrap) begin
                time_sec <= sec_wrap ? '0 : time_sec + 1'b1;
            end
            // minutes roll over to zero
            if (sec_wrap) begin
                time_min <= min_wrap ? '0 : time_min + 1'b1;
            end
        end
    end

endmodule

// File: rtl/game_status.sv
`timescale 1ns/100ps

module game_status (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   game_start,
    input  logic                   busy,
    input  tetris_pkg::board_row_t top_row,
    output logic                   in_game,
    output logic                   topped_out,
    output logic                   accept
);
    import tetris_pkg::*;

    status_t state;
    status_t state_next;
    logic    top_occupied;

    always_comb begin
        top_occupied = 1'b0;
        for (int c = 0; c < PLAYFIELD_COLS; c++) begin
            if (top_row[c] != BLANK) begin
                top_occupied = 1'b1;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:       state_next = IDLE;
            // top row only counts once the stack has settled
            IN_GAME:    if (!busy && top_occupied) state_next = TOPPED_OUT;
            TOPPED_OUT: state_next = TOPPED_OUT;
            default:    state_next = IDLE;
        endcase
        if (game_start) begin
            state_next = IN_GAME;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign in_game    = (state == IN_GAME);
    assign topped_out = (state == TOPPED_OUT);
    // host updates land only on a settled board during play
    assign accept     = in_game && !busy;

endmodule

// File: rtl/tetris_core_top.sv
`timescale 1ns/100ps

module tetris_core_top #(
    parameter int TICKS_PER_MS = 50000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   game_start,
    input  logic                   lock,
    input  tetris_pkg::tile_t      lock_type,
    input  tetris_pkg::row_idx_t   lock_rows [4],
    input  tetris_pkg::col_idx_t   lock_cols [4],
    input  logic                   load_garbage,
    input  tetris_pkg::col_idx_t   hole_col,
    input  tetris_pkg::row_idx_t   rd_row,
    output tetris_pkg::board_row_t rd_cells,
    output logic                   busy,
    output logic                   in_game,
    output logic                   topped_out,
    output tetris_pkg::lines_t     lines_cleared,
    output tetris_pkg::digit_t     time_ms,
    output tetris_pkg::digit_t     time_cs,
    output tetris_pkg::digit_t     time_ds,
    output tetris_pkg::sixty_t     time_sec,
    output tetris_pkg::sixty_t     time_min
);
    import tetris_pkg::*;

    board_row_t                board [PLAYFIELD_ROWS];
    logic [PLAYFIELD_ROWS-1:0] row_full;
    logic [PLAYFIELD_ROWS-1:0] row_empty;
    logic                      accept;

    playfield_store u_playfield_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .game_start   (game_start),
        .accept       (accept),
        .lock         (lock),
        .load_garbage (load_garbage),
        .lock_type    (lock_type),
        .lock_rows    (lock_rows),
        .lock_cols    (lock_cols),
        .hole_col     (hole_col),
        .row_full     (row_full),
        .row_empty    (row_empty),
        .board        (board)
    );

    line_tracker u_line_tracker (
        .clk           (clk),
        .rst_n         (rst_n),
        .game_start    (game_start),
        .board         (board),
        .row_full      (row_full),
        .row_empty     (row_empty),
        .busy          (busy),
        .lines_cleared (lines_cleared)
    );

    game_status u_game_status (
        .clk        (clk),
        .rst_n      (rst_n),
        .game_start (game_start),
        .busy       (busy),
        .top_row    (board[0]),
        .in_game    (in_game),
        .topped_out (topped_out),
        .accept     (accept)
    );

    // clock only runs during play
    sprint_timer #(
        .TICKS_PER_MS (TICKS_PER_MS)
    ) u_sprint_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .game_start (game_start),
        .run        (in_game),
        .time_ms    (time_ms),
        .time_cs    (time_cs),
        .time_ds    (time_ds),
        .time_sec   (time_sec),
        .time_min   (time_min)
    );

    // display read port, rows past the bottom read as blank
    always_comb begin
        rd_cells = '{default: BLANK};
        if (rd_row < PLAYFIELD_ROWS) begin
            rd_cells = board[rd_row];
        end
    end

endmodule

// File: tb/tb_tetris_core.sv
`timescale 1ns/100ps

module tb_tetris_core;
    import tetris_pkg::*;

    localparam int TICKS_PER_MS = 2;
    localparam int SETTLE_LIMIT = 100;
    localparam board_row_t BLANK_ROW = '{default: BLANK};

    logic       clk;
    logic       rst_n;
    logic       game_start;
    logic       lock;
    tile_t      lock_type;
    row_idx_t   lock_rows [4];
    col_idx_t   lock_cols [4];
    logic       load_garbage;
    col_idx_t   hole_col;
    row_idx_t   rd_row;
    board_row_t rd_cells;
    logic       busy;
    logic       in_game;
    logic       topped_out;
    lines_t     lines_cleared;
    digit_t     time_ms;
    digit_t     time_cs;
    digit_t     time_ds;
    sixty_t     time_sec;
    sixty_t     time_min;

    // reference playfield
    board_row_t model_board [PLAYFIELD_ROWS];
    lines_t     model_lines;

    int error_count;
    int test_count;
    int failed_tests;
    int start_errors;

    // clock edges seen so far, and the count at the last game start edge
    int cycle_count;
    int start_cycle;

    tetris_core_top #(
        .TICKS_PER_MS (TICKS_PER_MS)
    ) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .game_start    (game_start),
        .lock          (lock),
        .lock_type     (lock_type),
        .lock_rows     (lock_rows),
        .lock_cols     (lock_cols),
        .load_garbage  (load_garbage),
        .hole_col      (hole_col),
        .rd_row        (rd_row),
        .rd_cells      (rd_cells),
        .busy          (busy),
        .in_game       (in_game),
        .topped_out    (topped_out),
        .lines_cleared (lines_cleared),
        .time_ms       (time_ms),
        .time_cs       (time_cs),
        .time_ds       (time_ds),
        .time_sec      (time_sec),
        .time_min      (time_min)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
    end

    task automatic check_row(input string name, input board_row_t exp, input board_row_t act);
        if (act !== exp) begin
            $display("error: %s expected %h actual %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_lines(input string name, input lines_t exp, input lines_t act);
        if (act !== exp) begin
            $display("error: %s expected %0d actual %0d", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_digit(input string name, input digit_t exp, input digit_t act);
        if (act !== exp) begin
            $display("error: %s expected %0d actual %0d", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_sixty(input string name, input sixty_t exp, input sixty_t act);
        if (act !== exp) begin
            $display("error: %s expected %0d actual %0d", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: %s expected %b actual %b", name, exp, act);
            error_count++;
        end
    endtask

    // split a millisecond count into the five timer fields
    task automatic check_time(input string name, input int total_ms);
        check_digit($sformatf("%s ms", name), digit_t'(total_ms % 10), time_ms);
        check_digit($sformatf("%s cs", name), digit_t'((total_ms / 10) % 10), time_cs);
        check_digit($sformatf("%s ds", name), digit_t'((total_ms / 100) % 10), time_ds);
        check_sixty($sformatf("%s sec", name), sixty_t'((total_ms / 1000) % 60), time_sec);
        check_sixty($sformatf("%s min", name), sixty_t'((total_ms / 60000) % 60), time_min);
    endtask

    task automatic model_clear();
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            model_board[r] = BLANK_ROW;
        end
        model_lines = '0;
    endtask

    // drop full rows, then pack the rest at the bottom in order
    task automatic model_settle();
        board_row_t stacked [PLAYFIELD_ROWS];
        int         dst;
        bit         full;
        bit         empty;
        dst = PLAYFIELD_ROWS - 1;
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            stacked[r] = BLANK_ROW;
        end
        for (int r = PLAYFIELD_ROWS - 1; r >= 0; r--) begin
            full  = 1'b1;
            empty = 1'b1;
            for (int c = 0; c < PLAYFIELD_COLS; c++) begin
                if (model_board[r][c] == BLANK) begin
                    full = 1'b0;
                end else begin
                    empty = 1'b0;
                end
            end
            if (full) begin
                model_lines++;
            end else if (!empty) begin
                stacked[dst] = model_board[r];
                dst--;
            end
        end
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            model_board[r] = stacked[r];
        end
    endtask

    task automatic start_game();
        @(negedge clk);
        game_start = 1'b1;
        @(negedge clk);
        game_start = 1'b0;
        start_cycle = cycle_count;
        model_clear();
    endtask

    task automatic send_lock(input tile_t t, input int r0, input int c0, input int r1,
                             input int c1, input int r2, input int c2, input int r3,
                             input int c3, input bit taken);
        @(negedge clk);
        lock_type    = t;
        lock_rows[0] = row_idx_t'(r0);
        lock_cols[0] = col_idx_t'(c0);
        lock_rows[1] = row_idx_t'(r1);
        lock_cols[1] = col_idx_t'(c1);
        lock_rows[2] = row_idx_t'(r2);
        lock_cols[2] = col_idx_t'(c2);
        lock_rows[3] = row_idx_t'(r3);
        lock_cols[3] = col_idx_t'(c3);
        lock         = 1'b1;
        @(negedge clk);
        lock = 1'b0;
        if (taken) begin
            for (int k = 0; k < 4; k++) begin
                model_board[lock_rows[k]][lock_cols[k]] = t;
            end
            model_settle();
        end
    endtask

    task automatic send_garbage(input int hole, input bit taken);
        @(negedge clk);
        hole_col     = col_idx_t'(hole);
        load_garbage = 1'b1;
        @(negedge clk);
        load_garbage = 1'b0;
        if (taken) begin
            for (int r = 0; r < PLAYFIELD_ROWS - 1; r++) begin
                model_board[r] = model_board[r+1];
            end
            for (int c = 0; c < PLAYFIELD_COLS; c++) begin
                model_board[PLAYFIELD_ROWS-1][c] = (c == hole) ? BLANK : GARBAGE;
            end
        end
    endtask

    task automatic wait_settled(input string name);
        int cycles;
        cycles = 0;
        while (busy && cycles < SETTLE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("%s: busy still high after %0d cycles", name, SETTLE_LIMIT);
            error_count++;
        end
    endtask

    task automatic wait_topped_out(input string name);
        int cycles;
        cycles = 0;
        while (!topped_out && cycles < SETTLE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!topped_out) begin
            $display("%s: topped_out never rose within %0d cycles", name, SETTLE_LIMIT);
            error_count++;
        end
    endtask

    // read every row through the display port
    task automatic check_board(input string name);
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            @(negedge clk);
            rd_row = row_idx_t'(r);
            #10;
            check_row($sformatf("%s row %0d", name, r), model_board[r], rd_cells);
        end
    endtask

    task automatic begin_test();
        start_errors = error_count;
        test_count++;
    endtask

    task automatic end_test(input string name);
        if (error_count == start_errors) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: %0d mismatches", name, error_count - start_errors);
        end
    endtask

    task automatic test_reset_state();
        begin_test();
        check_bit("reset_state in_game", 1'b0, in_game);
        check_bit("reset_state topped_out", 1'b0, topped_out);
        check_bit("reset_state busy", 1'b0, busy);
        check_lines("reset_state lines", '0, lines_cleared);
        check_digit("reset_state ms", '0, time_ms);
        check_digit("reset_state cs", '0, time_cs);
        check_digit("reset_state ds", '0, time_ds);
        check_sixty("reset_state sec", '0, time_sec);
        check_sixty("reset_state min", '0, time_min);
        check_board("reset_state");
        end_test("reset_state");
    endtask

    task automatic test_lock_gating();
        begin_test();
        // no game running yet
        send_lock(T, 19, 0, 19, 1, 19, 2, 18, 1, 1'b0);
        check_board("lock_gating idle");
        start_game();
        check_bit("lock_gating in_game", 1'b1, in_game);
        // upward T placed mid-board so it has to fall
        send_lock(T, 10, 4, 11, 3, 11, 4, 11, 5, 1'b1);
        wait_settled("lock_gating");
        check_board("lock_gating");
        end_test("lock_gating");
    endtask

    task automatic test_line_clear();
        begin_test();
        start_game();
        send_lock(I, 19, 0, 19, 1, 19, 2, 19, 3, 1'b1);
        wait_settled("line_clear");
        send_lock(I, 19, 4, 19, 5, 19, 6, 19, 7, 1'b1);
        wait_settled("line_clear");
        send_lock(O, 18, 8, 18, 9, 19, 8, 19, 9, 1'b1);
        wait_settled("line_clear");
        check_board("line_clear");
        check_lines("line_clear lines", model_lines, lines_cleared);
        end_test("line_clear");
    endtask

    task automatic test_garbage();
        int hole;
        begin_test();
        hole = int'($urandom % PLAYFIELD_COLS);
        send_garbage(hole, 1'b1);
        wait_settled("garbage");
        check_board("garbage");
        check_lines("garbage lines", model_lines, lines_cleared);
        end_test("garbage");
    endtask

    task automatic test_timer();
        begin_test();
        start_game();
        repeat (2468) @(posedge clk);
        @(negedge clk);
        check_bit("timer in_game", 1'b1, in_game);
        check_lines("timer lines", model_lines, lines_cleared);
        check_time("timer", 2468 / TICKS_PER_MS);
        end_test("timer");
    endtask

    task automatic test_top_out();
        int active_ms;
        begin_test();
        // push garbage until the stack reaches row 0
        for (int i = 0; i < 2 * PLAYFIELD_ROWS && model_board[0] == BLANK_ROW; i++) begin
            send_garbage(int'($urandom % PLAYFIELD_COLS), 1'b1);
            wait_settled("top_out");
        end
        // the timer still steps on the top-out edge, one edge after row 0 fills
        active_ms = (cycle_count - start_cycle + 1) / TICKS_PER_MS;
        wait_topped_out("top_out");
        check_bit("top_out in_game", 1'b0, in_game);
        check_bit("top_out topped_out", 1'b1, topped_out);
        check_time("top_out", active_ms);
        repeat (10 * TICKS_PER_MS) @(negedge clk);
        check_time("top_out hold", active_ms);
        send_lock(T, 5, 4, 6, 3, 6, 4, 6, 5, 1'b0);
        check_board("top_out");
        end_test("top_out");
    endtask

    initial begin
        void'($urandom(32'h8dee8b23));
        clk          = 1'b0;
        rst_n        = 1'b0;
        game_start   = 1'b0;
        lock         = 1'b0;
        lock_type    = BLANK;
        load_garbage = 1'b0;
        hole_col     = '0;
        rd_row       = '0;
        for (int k = 0; k < 4; k++) begin
            lock_rows[k] = '0;
            lock_cols[k] = '0;
        end
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        start_errors = 0;
        cycle_count  = 0;
        start_cycle  = 0;
        model_clear();

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_lock_gating();
        test_line_clear();
        test_garbage();
        test_timer();
        test_top_out();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: src.f
rtl/tetris_pkg.sv
rtl/playfield_store.sv
rtl/line_tracker.sv
rtl/sprint_timer.sv
rtl/game_status.sv
rtl/tetris_core_top.sv
tb/tb_tetris_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_tetris_core
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
